// ==== cnn_top.f ====
+incdir+src
+incdir+dv
src/cnn_pkg.sv
src/cnn_loader.sv
src/cnn_window_scan.sv
src/cnn_mac.sv
src/cnn_max_pool.sv
src/cnn_top.sv
dv/cnn_tb.sv

// ==== dv/cnn_ref_model.svh ====
/*
 * Convolution engine reference model
 * Padding, 2x2 convolution and 3x3 max pooling of frame_img and frame_ker.
 */
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

    function automatic int clamp_index(input int v);
        if (v < 0) return 0;
        if (v > `CNN_IMG_DIM - 1) return `CNN_IMG_DIM - 1;
        return v;
    endfunction

    // value at (r, c) of the 7x7 padded grid
    function automatic int padded_value(input int r, input int c, input pad_mode_e mode);
        int ir;
        int ic;
        ir = r - 1;
        ic = c - 1;
        if (ir >= 0 && ir < `CNN_IMG_DIM && ic >= 0 && ic < `CNN_IMG_DIM) begin
            return int'(frame_img[ir * `CNN_IMG_DIM + ic]);
        end
        if (mode == PAD_ZERO) return 0;
        return int'(frame_img[clamp_index(ir) * `CNN_IMG_DIM + clamp_index(ic)]);
    endfunction

    function automatic int conv_value(input int i, input int j, input pad_mode_e mode);
        int acc;
        acc = 0;
        for (int kr = 0; kr < `CNN_KER_DIM; kr++) begin
            for (int kc = 0; kc < `CNN_KER_DIM; kc++) begin
                acc += padded_value(i + kr, j + kc, mode)
                     * int'(frame_ker[kr * `CNN_KER_DIM + kc]);
            end
        end
        return acc;
    endfunction

    // regions in order top-left, top-right, bottom-left, bottom-right
    task automatic predict_pool(input pad_mode_e mode);
        int best;
        int v;
        int r0;
        int c0;
        for (int q = 0; q < `CNN_POOL_OUT; q++) begin
            r0   = (q / 2) * `CNN_POOL_WIN;
            c0   = (q % 2) * `CNN_POOL_WIN;
            best = conv_value(r0, c0, mode);
            for (int dr = 0; dr < `CNN_POOL_WIN; dr++) begin
                for (int dc = 0; dc < `CNN_POOL_WIN; dc++) begin
                    v = conv_value(r0 + dr, c0 + dc, mode);
                    if (v > best) best = v;
                end
            end
            exp_max[q] = sum_t'(best);
        end
    endtask

`endif

// ==== dv/cnn_tb.sv ====
/*
 * Convolution engine testbench
 * Directed tests of both padding modes, signed range, output timing,
 * random frames and reset recovery against a reference model.
 */
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_tb;

    import cnn_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_FRAMES      = 18;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 80 + 200;
    localparam int OUT_LATENCY     = 40;
    localparam int RESULT_WAIT     = 60;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    pixel_t    img_pixel;
    pixel_t    kernel_coef;
    pad_mode_e pad_mode;
    logic      out_valid;
    sum_t      out_data;

    // frame under test, model maxima and observed maxima
    pixel_t frame_img [0:`CNN_IMG_PIX-1];
    pixel_t frame_ker [0:`CNN_KER_TAPS-1];
    sum_t   exp_max [0:`CNN_POOL_OUT-1];
    sum_t   got_max [0:`CNN_POOL_OUT-1];
    sum_t   zero_max [0:`CNN_POOL_OUT-1];
    int     n_beats;
    int     first_lat;
    int     error_count;
    int     check_total;

    `include "cnn_ref_model.svh"

    cnn_top uut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .img_pixel(img_pixel),
        .kernel_coef(kernel_coef), .pad_mode(pad_mode),
        .out_valid(out_valid), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, tests did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_sum(input string name, input sum_t exp, input sum_t act);
        check_total++;
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_total++;
        if (act != exp) begin
            error_count++;
            if (act == 0) $display("ERROR: %s: out_valid never came", name);
            else $display("ERROR: %s: out_valid pulsed %0d times instead of %0d",
                          name, act, exp);
        end
    endtask

    task automatic compare_latency(input string name, input int exp, input int act);
        check_total++;
        if (act != exp) begin
            error_count++;
            $display("[FAIL] %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // --------------------------------------------------
    // drive and collect
    // --------------------------------------------------
    task automatic drive_frame(input pad_mode_e mode, input int beats);
        for (int b = 0; b < beats; b++) begin
            @(negedge clk);
            in_valid    = 1'b1;
            img_pixel   = frame_img[b];
            // later coefficients and modes must be ignored by the loader
            kernel_coef = (b < `CNN_KER_TAPS) ? frame_ker[b] : pixel_t'($urandom);
            pad_mode    = (b == 0) ? mode : ((mode == PAD_ZERO) ? PAD_REPLICATE : PAD_ZERO);
        end
        @(negedge clk);
        in_valid    = 1'b0;
        img_pixel   = '0;
        kernel_coef = '0;
        pad_mode    = PAD_ZERO;
    endtask

    // cyc counts rising edges since the edge that took the last beat
    task automatic collect_results(input string name);
        int cyc;
        bit done;
        cyc       = 0;
        done      = 1'b0;
        n_beats   = 0;
        first_lat = -1;
        while (!done && cyc < RESULT_WAIT) begin
            if (out_valid) begin
                if (n_beats == 0) first_lat = cyc;
                if (n_beats < `CNN_POOL_OUT) got_max[n_beats] = out_data;
                n_beats++;
            end else begin
                check_sum({name, " idle out_data"}, '0, out_data);
                done = (n_beats > 0);
            end
            if (!done) begin
                @(negedge clk);
                cyc++;
            end
        end
    endtask

    task automatic run_frame(input string name, input pad_mode_e mode);
        drive_frame(mode, `CNN_IMG_PIX);
        collect_results(name);
        predict_pool(mode);
        check_count(name, `CNN_POOL_OUT, n_beats);
        if (first_lat >= 0) compare_latency(name, OUT_LATENCY, first_lat);
        for (int q = 0; q < `CNN_POOL_OUT && q < n_beats; q++) begin
            check_sum($sformatf("%s region %0d", name, q), exp_max[q], got_max[q]);
        end
    endtask

    task automatic ramp_frame();
        for (int p = 0; p < `CNN_IMG_PIX; p++) frame_img[p] = pixel_t'(5 * p - 60);
        frame_ker[0] = 8'sd1;
        frame_ker[1] = -8'sd1;
        frame_ker[2] = 8'sd2;
        frame_ker[3] = 8'sd0;
    endtask

    task automatic random_frame();
        for (int p = 0; p < `CNN_IMG_PIX; p++) frame_img[p] = pixel_t'($urandom);
        for (int k = 0; k < `CNN_KER_TAPS; k++) frame_ker[k] = pixel_t'($urandom);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic zero_padding();
        ramp_frame();
        run_frame("zero_padding", PAD_ZERO);
        for (int q = 0; q < `CNN_POOL_OUT; q++) zero_max[q] = got_max[q];
    endtask

    task automatic edge_replication();
        int diffs;
        ramp_frame();
        run_frame("edge_replication", PAD_REPLICATE);
        diffs = 0;
        for (int q = 0; q < `CNN_POOL_OUT; q++) if (got_max[q] !== zero_max[q]) diffs++;
        check_total++;
        if (diffs == 0) begin
            error_count++;
            $display("ERROR: edge_replication: results equal the zero padded ones");
        end
    endtask

    task automatic signed_extremes();
        for (int p = 0; p < `CNN_IMG_PIX; p++) frame_img[p] = -8'sd128;
        for (int k = 0; k < `CNN_KER_TAPS; k++) frame_ker[k] = -8'sd128;
        run_frame("extremes_min", PAD_REPLICATE);
        check_sum("extremes_min full scale", 18'sd65536, got_max[0]);
        // checkerboard, since the image side is odd
        for (int p = 0; p < `CNN_IMG_PIX; p++) frame_img[p] = (p % 2) ? -8'sd128 : 8'sd127;
        frame_ker[0] = 8'sd127;
        frame_ker[1] = -8'sd128;
        frame_ker[2] = -8'sd128;
        frame_ker[3] = 8'sd127;
        run_frame("extremes_mixed", PAD_ZERO);
        // replicated edges keep every window at the full negative sum
        for (int p = 0; p < `CNN_IMG_PIX; p++) frame_img[p] = 8'sd127;
        for (int k = 0; k < `CNN_KER_TAPS; k++) frame_ker[k] = -8'sd128;
        run_frame("extremes_negative", PAD_REPLICATE);
    endtask

    task automatic output_timing();
        random_frame();
        run_frame("output_timing", PAD_ZERO);
    endtask

    task automatic random_frames();
        for (int f = 0; f < 10; f++) begin
            random_frame();
            run_frame($sformatf("random_%0d", f),
                      ($urandom % 2 == 0) ? PAD_ZERO : PAD_REPLICATE);
        end
    endtask

    task automatic reset_recovery();
        int pulses;
        random_frame();
        drive_frame(PAD_ZERO, 12);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n  = 1'b1;
        pulses = 0;
        repeat (RESULT_WAIT) begin
            @(negedge clk);
            if (out_valid) pulses++;
        end
        check_count("reset_recovery idle", 0, pulses);
        random_frame();
        run_frame("reset_recovery", PAD_REPLICATE);
    endtask

    initial begin
        error_count = 0;
        check_total = 0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        img_pixel   = '0;
        kernel_coef = '0;
        pad_mode    = PAD_ZERO;
        void'($urandom(32'h79eca78d));
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        zero_padding();
        edge_replication();
        signed_extremes();
        output_timing();
        random_frames();
        reset_recovery();

        $display("checks: %0d, errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/cnn_top.sv ====
/*
 * Streaming convolution engine
 * Loader, window scanner, multiply-accumulate and max pooling in a chain.
 */
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  cnn_pkg::pixel_t     img_pixel,
    input  cnn_pkg::pixel_t     kernel_coef,
    input  cnn_pkg::pad_mode_e  pad_mode,
    output logic                out_valid,
    output cnn_pkg::sum_t       out_data
);

    import cnn_pkg::*;

    pixel_t    image [0:`CNN_IMG_PIX-1];
    pixel_t    kernel [0:`CNN_KER_TAPS-1];
    pad_mode_e frame_pad;
    logic      frame_ready;
    logic      win_valid;
    pixel_t    win_px [0:`CNN_KER_TAPS-1];
    logic      conv_valid;
    sum_t      conv_sum;

    cnn_loader u_loader (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .img_pixel(img_pixel), .kernel_coef(kernel_coef), .pad_mode(pad_mode),
        .image(image), .kernel(kernel), .frame_pad(frame_pad),
        .frame_ready(frame_ready)
    );

    cnn_window_scan u_scan (
        .clk(clk), .rst_n(rst_n), .frame_ready(frame_ready),
        .image(image), .frame_pad(frame_pad),
        .win_valid(win_valid), .win_px(win_px)
    );

    cnn_mac u_mac (
        .clk(clk), .rst_n(rst_n), .win_valid(win_valid),
        .win_px(win_px), .kernel(kernel),
        .conv_valid(conv_valid), .conv_sum(conv_sum)
    );

    cnn_max_pool u_pool (
        .clk(clk), .rst_n(rst_n), .conv_valid(conv_valid), .conv_sum(conv_sum),
        .out_valid(out_valid), .out_data(out_data)
    );

endmodule

// ==== src/cnn_max_pool.sv ====
/*
 * Max pooling stage
 * Folds the 6x6 feature map into four 3x3 maxima and streams them out
 * in region order once the last result has arrived.
 */
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_max_pool (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           conv_valid,
    input  cnn_pkg::sum_t  conv_sum,
    output logic           out_valid,
    output cnn_pkg::sum_t  out_data
);

    import cnn_pkg::*;

    localparam int MAP_LAST = `CNN_MAP_DIM - 1;
    localparam int OUT_LAST = `CNN_POOL_OUT - 1;

    logic [2:0] row_cnt;
    logic [2:0] col_cnt;
    logic [1:0] region;
    logic       region_first;
    logic       map_done;
    logic       draining;
    logic [1:0] out_idx;
    sum_t       max_q [0:`CNN_POOL_OUT-1];

    // two regions per side, so the quotient is a compare
    assign region       = {row_cnt >= `CNN_POOL_WIN, col_cnt >= `CNN_POOL_WIN};
    assign region_first = (row_cnt == 0 || row_cnt == `CNN_POOL_WIN) &&
                          (col_cnt == 0 || col_cnt == `CNN_POOL_WIN);
    assign map_done     = (row_cnt == MAP_LAST) && (col_cnt == MAP_LAST);

    // --------------------------------------------------
    // map position and output sequencing
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt   <= '0;
            col_cnt   <= '0;
            draining  <= 1'b0;
            out_idx   <= '0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            if (conv_valid) begin
                if (col_cnt == MAP_LAST) begin
                    col_cnt <= '0;
                    row_cnt <= map_done ? 3'd0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
            out_valid <= draining;
            out_data  <= draining ? max_q[out_idx] : '0;
            if (conv_valid && map_done) begin
                draining <= 1'b1;
            end else if (draining) begin
                out_idx <= out_idx + 1'b1;
                if (out_idx == OUT_LAST) draining <= 1'b0;
            end
        end
    end

    // running maxima, seeded by each region's first result
    always_ff @(posedge clk) begin
        if (conv_valid) begin
            if (region_first || conv_sum > max_q[region]) begin
                max_q[region] <= conv_sum;
            end
        end
    end

endmodule

// ==== src/cnn_mac.sv ====
/*
 * Multiply-accumulate stage
 * Two-cycle pipeline: four signed products, then their sum.
 */
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_mac (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             win_valid,
    input  cnn_pkg::pixel_t  win_px [0:`CNN_KER_TAPS-1],
    input  cnn_pkg::pixel_t  kernel [0:`CNN_KER_TAPS-1],
    output logic             conv_valid,
    output cnn_pkg::sum_t    conv_sum
);

    import cnn_pkg::*;

    localparam int PROD_W = 2 * `CNN_DATA_W;

    logic signed [PROD_W-1:0] prod [0:`CNN_KER_TAPS-1];
    logic                     prod_valid;

    // --------------------------------------------------
    // valid pipe
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            conv_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            conv_valid <= prod_valid;
        end
    end

    // stage one, products
    always_ff @(posedge clk) begin
        for (int k = 0; k < `CNN_KER_TAPS; k++) begin
            prod[k] <= win_px[k] * kernel[k];
        end
    end

    // stage two, adder tree widened to the sum format
    always_ff @(posedge clk) begin
        conv_sum <= sum_t'(prod[0]) + sum_t'(prod[1])
                  + sum_t'(prod[2]) + sum_t'(prod[3]);
    end

endmodule

// ==== src/cnn_window_scan.sv ====
/*
 * Window scanner
 * Steps over the 6x6 convolution positions after frame_ready and emits
 * one padded 2x2 window per cycle, zero padded or edge replicated.
 */
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_window_scan (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frame_ready,
    input  cnn_pkg::pixel_t     image [0:`CNN_IMG_PIX-1],
    input  cnn_pkg::pad_mode_e  frame_pad,
    output logic                win_valid,
    output cnn_pkg::pixel_t     win_px [0:`CNN_KER_TAPS-1]
);

    import cnn_pkg::*;

    localparam int MAP_LAST = `CNN_MAP_DIM - 1;
    localparam int IMG_LAST = `CNN_IMG_DIM - 1;

    scan_state_e state;
    logic [2:0]  row_cnt;
    logic [2:0]  col_cnt;
    logic        emit;
    logic        last_pos;

    // padded (r, c) sits on image pixel (r-1, c-1)
    function automatic pixel_t padded_px(input int r, input int c, input pad_mode_e mode);
        int ir;
        int ic;
        ir = r - 1;
        ic = c - 1;
        if (mode == PAD_ZERO &&
            (ir < 0 || ir > IMG_LAST || ic < 0 || ic > IMG_LAST)) begin
            return '0;
        end
        // clamp onto the nearest edge
        if (ir < 0) ir = 0;
        if (ir > IMG_LAST) ir = IMG_LAST;
        if (ic < 0) ic = 0;
        if (ic > IMG_LAST) ic = IMG_LAST;
        return image[ir * `CNN_IMG_DIM + ic];
    endfunction

    // first window goes out on the strobe itself, counters idle at zero
    assign emit     = (state == SCAN_RUN) || frame_ready;
    assign last_pos = (row_cnt == MAP_LAST) && (col_cnt == MAP_LAST);

    // --------------------------------------------------
    // position counters and state
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SCAN_IDLE;
            row_cnt   <= '0;
            col_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= emit;
            if (emit) begin
                if (last_pos) begin
                    state   <= SCAN_IDLE;
                    row_cnt <= '0;
                    col_cnt <= '0;
                end else begin
                    state <= SCAN_RUN;
                    if (col_cnt == MAP_LAST) begin
                        col_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // window taps in raster order
    always_ff @(posedge clk) begin
        if (emit) begin
            win_px[0] <= padded_px(int'(row_cnt), int'(col_cnt), frame_pad);
            win_px[1] <= padded_px(int'(row_cnt), int'(col_cnt) + 1, frame_pad);
            win_px[2] <= padded_px(int'(row_cnt) + 1, int'(col_cnt), frame_pad);
            win_px[3] <= padded_px(int'(row_cnt) + 1, int'(col_cnt) + 1, frame_pad);
        end
    end

endmodule

// ==== src/cnn_loader.sv ====
/*
 * Frame loader
 * Captures 25 streamed pixels, the first four kernel coefficients and
 * the padding mode, then strobes frame_ready once the frame is complete.
 */
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_loader (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  cnn_pkg::pixel_t     img_pixel,
    input  cnn_pkg::pixel_t     kernel_coef,
    input  cnn_pkg::pad_mode_e  pad_mode,
    output cnn_pkg::pixel_t     image [0:`CNN_IMG_PIX-1],
    output cnn_pkg::pixel_t     kernel [0:`CNN_KER_TAPS-1],
    output cnn_pkg::pad_mode_e  frame_pad,
    output logic                frame_ready
);

    import cnn_pkg::*;

    localparam int LAST_BEAT = `CNN_IMG_PIX - 1;

    logic [$clog2(`CNN_IMG_PIX)-1:0] beat_cnt;

    // --------------------------------------------------
    // beat counter, mode latch and frame strobe
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt    <= '0;
            frame_pad   <= PAD_ZERO;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= 1'b0;
            if (in_valid) begin
                if (beat_cnt == '0) begin
                    frame_pad <= pad_mode;
                end
                if (beat_cnt == LAST_BEAT) begin
                    beat_cnt    <= '0;
                    frame_ready <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // image and kernel storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid) begin
            image[beat_cnt] <= img_pixel;
            // kernel rides on the first four beats only
            if (beat_cnt < `CNN_KER_TAPS) begin
                kernel[beat_cnt[1:0]] <= kernel_coef;
            end
        end
    end

endmodule

// ==== src/cnn_pkg.sv ====
/*
 * Convolution engine types
 * Pixel and sum formats, padding opcode and scanner state.
 */
`include "cnn_defs.svh"

package cnn_pkg;

    // signed pixel or kernel coefficient
    typedef logic signed [`CNN_DATA_W-1:0] pixel_t;

    // signed convolution sum, also the pooled result
    typedef logic signed [`CNN_SUM_W-1:0] sum_t;

    typedef enum logic {
        PAD_ZERO      = 1'b0,
        PAD_REPLICATE = 1'b1
    } pad_mode_e;

    typedef enum logic {
        SCAN_IDLE = 1'b0,
        SCAN_RUN  = 1'b1
    } scan_state_e;

endpackage

// ==== src/cnn_defs.svh ====
/*
 * Convolution engine constants
 * Image, kernel, feature map and pooling sizes, and data path widths.
 */
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// data path widths
`define CNN_DATA_W   8
`define CNN_SUM_W    18

// frame geometry
`define CNN_IMG_DIM  5
`define CNN_IMG_PIX  25
`define CNN_KER_DIM  2
`define CNN_KER_TAPS 4
`define CNN_MAP_DIM  6
`define CNN_POOL_WIN 3
`define CNN_POOL_OUT 4

// cycles from window to sum
`define CNN_MAC_LAT  2

`endif
